// File: rtl/denoise_macros.svh
`ifndef DENOISE_MACROS_SVH
`define DENOISE_MACROS_SVH

// Bus word and channel widths
`define PIX_W   32
`define CH_W    8

// Block geometry, 8x8 pixels
`define BLK_PIX 64
`define BLK_LOG 6

// Accumulator widths, sized for 64 full-scale pixels
`define SUM_W   14
`define SQ_W    22

// Variance and noise variance
`define VAR_W   16

// Q8 gain, wide enough to hold 256
`define GAIN_W  9

`endif

// File: rtl/denoise_pkg.sv
`include "denoise_macros.svh"

package denoise_pkg;

	// One stream word, seen either raw or per channel
	typedef union packed {
		logic [`PIX_W-1:0] word;
		struct packed {
			logic [`CH_W-1:0] pad;
			logic [`CH_W-1:0] r;
			logic [`CH_W-1:0] g;
			logic [`CH_W-1:0] b;
		} ch;
	} pixel_t;

endpackage

// File: rtl/block_stats.sv
`timescale 1ns/1ps
`include "denoise_macros.svh"

module block_stats (
	input  logic                  clk,
	input  logic                  rst,
	input  denoise_pkg::pixel_t   s_data,
	input  logic                  s_valid,
	output logic                  s_ready,
	output logic                  wr_en,
	output logic                  wr_commit,
	output logic [`BLK_LOG-1:0]   wr_addr,
	output denoise_pkg::pixel_t   wr_data,
	input  logic                  wr_room,
	output logic                  stats_valid,
	input  logic                  stats_ready,
	output logic [3*`SUM_W-1:0]   sums,
	output logic [3*`SQ_W-1:0]    sumsqs
);

	logic [`BLK_LOG-1:0] cnt;
	logic                cnt_last;
	logic                accept;
	logic [`CH_W-1:0]    px [3];
	logic [2*`CH_W-1:0]  px_sq [3];
	logic [`SUM_W-1:0]   acc_sum [3];
	logic [`SQ_W-1:0]    acc_sq [3];
	logic [`SUM_W-1:0]   sum_nxt [3];
	logic [`SQ_W-1:0]    sq_nxt [3];

	assign cnt_last = (cnt == `BLK_LOG'(`BLK_PIX - 1));

	// Hold off the last pixel until the previous totals are taken
	assign s_ready   = wr_room && !(cnt_last && stats_valid);
	assign accept    = s_valid && s_ready;
	assign wr_en     = accept;
	assign wr_addr   = cnt;
	assign wr_data   = s_data;
	assign wr_commit = accept && cnt_last;

	// Index 2 is red so that it lands in the top field
	assign px[2] = s_data.ch.r;
	assign px[1] = s_data.ch.g;
	assign px[0] = s_data.ch.b;

	always_comb begin
		for (int c = 0; c < 3; c++) begin
			px_sq[c]   = px[c] * px[c];
			sum_nxt[c] = acc_sum[c] + {{(`SUM_W - `CH_W){1'b0}}, px[c]};
			sq_nxt[c]  = acc_sq[c] + {{(`SQ_W - 2*`CH_W){1'b0}}, px_sq[c]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt         <= '0;
			stats_valid <= 1'b0;
			for (int c = 0; c < 3; c++) begin
				acc_sum[c] <= '0;
				acc_sq[c]  <= '0;
			end
		end else begin
			if (accept)
				cnt <= cnt + 1'b1;
			if (wr_commit)
				stats_valid <= 1'b1;
			else if (stats_ready)
				stats_valid <= 1'b0;
			// Restart the accumulators at each block boundary
			for (int c = 0; c < 3; c++) begin
				if (wr_commit) begin
					acc_sum[c] <= '0;
					acc_sq[c]  <= '0;
				end else if (accept) begin
					acc_sum[c] <= sum_nxt[c];
					acc_sq[c]  <= sq_nxt[c];
				end
			end
		end
	end

	// Block totals, held for the gain stage
	always_ff @(posedge clk) begin
		if (wr_commit) begin
			for (int c = 0; c < 3; c++) begin
				sums[c*`SUM_W +: `SUM_W] <= sum_nxt[c];
				sumsqs[c*`SQ_W +: `SQ_W] <= sq_nxt[c];
			end
		end
	end

endmodule

// File: rtl/block_buffer.sv
`timescale 1ns/1ps
`include "denoise_macros.svh"

module block_buffer (
	input  logic                clk,
	input  logic                rst,
	input  logic                wr_en,
	input  logic                wr_commit,
	input  logic [`BLK_LOG-1:0] wr_addr,
	input  denoise_pkg::pixel_t wr_data,
	output logic                wr_room,
	input  logic [`BLK_LOG-1:0] rd_addr,
	output denoise_pkg::pixel_t rd_data,
	input  logic                rd_release
);
	import denoise_pkg::*;

	// Two banks of one block each, bank select is the top address bit
	pixel_t mem [2*`BLK_PIX];
	logic   wr_bank;
	logic   rd_bank;
	logic   full [2];

	assign wr_room = !full[wr_bank];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[{wr_bank, wr_addr}] <= wr_data;
		rd_data <= mem[{rd_bank, rd_addr}];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_bank <= 1'b0;
			rd_bank <= 1'b0;
			full[0] <= 1'b0;
			full[1] <= 1'b0;
		end else begin
			if (wr_commit) begin
				full[wr_bank] <= 1'b1;
				wr_bank       <= !wr_bank;
			end
			if (rd_release) begin
				full[rd_bank] <= 1'b0;
				rd_bank       <= !rd_bank;
			end
		end
	end

	// Writer must never touch a bank still waiting to be read
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> wr_room);

endmodule

// File: rtl/wiener_gain.sv
`timescale 1ns/1ps
`include "denoise_macros.svh"

module wiener_gain (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [`VAR_W-1:0]     noise_var,
	input  logic                  stats_valid,
	output logic                  stats_ready,
	input  logic [3*`SUM_W-1:0]   sums,
	input  logic [3*`SQ_W-1:0]    sumsqs,
	output logic                  params_valid,
	input  logic                  params_ready,
	output logic [3*`CH_W-1:0]    means,
	output logic [3*`GAIN_W-1:0]  gains
);

	logic [`CH_W-1:0]   mean_c [3];
	logic [`VAR_W-1:0]  sq_mean [3];
	logic [`VAR_W-1:0]  var_c [3];
	logic [`VAR_W-1:0]  var_r [3];
	logic               accept;
	logic               busy;
	logic               last_it;
	logic [1:0]         ch;
	logic [4:0]         it;
	logic [`VAR_W-1:0]  dvsr;
	logic [`VAR_W-1:0]  ld_var;
	logic [`VAR_W-1:0]  ld_diff;
	logic [`VAR_W-1:0]  rem;
	logic [`VAR_W:0]    dvd;
	logic [`VAR_W:0]    trial;
	logic [`VAR_W:0]    sub;
	logic               q_bit;
	logic [`GAIN_W-1:0] quo;
	logic [`GAIN_W-1:0] quo_nxt;

	assign stats_ready = !busy && !params_valid;
	assign accept      = stats_valid && stats_ready;
	assign last_it     = (it == 5'(`VAR_W));

	// Mean and variance straight from the block totals
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			mean_c[c]  = sums[c*`SUM_W + `BLK_LOG +: `CH_W];
			sq_mean[c] = sumsqs[c*`SQ_W + `BLK_LOG +: `VAR_W];
			var_c[c]   = sq_mean[c] - mean_c[c] * mean_c[c];
		end
	end

	assign dvsr = (ch == 2'd0) ? var_r[0] : (ch == 2'd1) ? var_r[1] : var_r[2];

	// Next channel to divide, channel 0 comes straight from the inputs
	assign ld_var  = accept ? var_c[0] : (ch == 2'd0) ? var_r[1] : var_r[2];
	assign ld_diff = (ld_var > noise_var) ? ld_var - noise_var : '0;

	// One restoring step, dividend is diff scaled by 256
	assign trial   = {rem, dvd[`VAR_W]};
	assign sub     = trial - {1'b0, dvsr};
	assign q_bit   = (trial >= {1'b0, dvsr});
	assign quo_nxt = {quo[`GAIN_W-2:0], q_bit};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy         <= 1'b0;
			params_valid <= 1'b0;
			ch           <= '0;
			it           <= '0;
		end else if (accept) begin
			busy <= 1'b1;
			ch   <= '0;
			it   <= '0;
		end else if (busy) begin
			if (last_it) begin
				it <= '0;
				if (ch == 2'd2) begin
					busy         <= 1'b0;
					params_valid <= 1'b1;
				end else begin
					ch <= ch + 1'b1;
				end
			end else begin
				it <= it + 1'b1;
			end
		end else if (params_ready) begin
			params_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int c = 0; c < 3; c++) begin
				var_r[c]                <= var_c[c];
				means[c*`CH_W +: `CH_W] <= mean_c[c];
			end
		end
		// Top 7 dividend bits seed the remainder, the rest shift in
		if (accept || (busy && last_it)) begin
			rem <= ld_diff >> (`VAR_W - `CH_W + 1);
			dvd <= {ld_diff[`VAR_W-`CH_W:0], {`CH_W{1'b0}}};
		end else if (busy) begin
			rem <= q_bit ? sub[`VAR_W-1:0] : trial[`VAR_W-1:0];
			dvd <= {dvd[`VAR_W-1:0], 1'b0};
		end
		if (busy)
			quo <= quo_nxt;
		// Flat block gets no gain at all
		if (busy && last_it)
			gains[ch*`GAIN_W +: `GAIN_W] <= (dvsr == '0) ? '0 : quo_nxt;
	end

	a_gain_range: assert property (@(posedge clk) disable iff (rst)
		params_valid |-> (gains[0 +: `GAIN_W] <= 9'd256) &&
			(gains[`GAIN_W +: `GAIN_W] <= 9'd256) &&
			(gains[2*`GAIN_W +: `GAIN_W] <= 9'd256));

endmodule

// File: rtl/wiener_apply.sv
`timescale 1ns/1ps
`include "denoise_macros.svh"

module wiener_apply (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 params_valid,
	output logic                 params_ready,
	input  logic [3*`CH_W-1:0]   means,
	input  logic [3*`GAIN_W-1:0] gains,
	output logic [`BLK_LOG-1:0]  rd_addr,
	input  denoise_pkg::pixel_t  rd_data,
	output logic                 rd_release,
	output denoise_pkg::pixel_t  m_data,
	output logic                 m_valid,
	input  logic                 m_ready,
	output logic                 m_last
);

	logic                            active;
	logic                            out_hs;
	logic [`BLK_LOG-1:0]             idx;
	logic [3*`CH_W-1:0]              mean_r;
	logic [3*`GAIN_W-1:0]            gain_r;
	logic [`CH_W-1:0]                px [3];
	logic signed [`CH_W:0]           dlt [3];
	logic signed [`CH_W+`GAIN_W+1:0] prod [3];
	logic signed [`CH_W+2:0]         filt [3];
	logic [`CH_W-1:0]                y [3];

	assign params_ready = !active;
	assign rd_addr      = idx;
	assign out_hs       = m_valid && m_ready;
	assign m_last       = m_valid && (idx == `BLK_LOG'(`BLK_PIX - 1));
	assign rd_release   = out_hs && m_last;

	assign px[2] = rd_data.ch.r;
	assign px[1] = rd_data.ch.g;
	assign px[0] = rd_data.ch.b;

	// mean + floor(gain * (x - mean) / 256), then clamp to a byte
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			dlt[c]  = $signed({1'b0, px[c]}) - $signed({1'b0, mean_r[c*`CH_W +: `CH_W]});
			prod[c] = $signed({1'b0, gain_r[c*`GAIN_W +: `GAIN_W]}) * dlt[c];
			filt[c] = $signed({3'b000, mean_r[c*`CH_W +: `CH_W]}) +
				$signed(prod[c][2*`CH_W+2:`CH_W]);
			if (filt[c][`CH_W+2])
				y[c] = '0;
			else if (|filt[c][`CH_W+1:`CH_W])
				y[c] = '1;
			else
				y[c] = filt[c][`CH_W-1:0];
		end
		m_data.word = '0;
		m_data.ch.r = y[2];
		m_data.ch.g = y[1];
		m_data.ch.b = y[0];
	end

	// Read cycle, then output held until taken
	always_ff @(posedge clk) begin
		if (rst) begin
			active  <= 1'b0;
			m_valid <= 1'b0;
			idx     <= '0;
		end else begin
			if (params_valid && params_ready)
				active <= 1'b1;
			else if (rd_release)
				active <= 1'b0;
			if (out_hs)
				m_valid <= 1'b0;
			else if (active)
				m_valid <= 1'b1;
			if (out_hs)
				idx <= idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (params_valid && params_ready) begin
			mean_r <= means;
			gain_r <= gains;
		end
	end

	// Buffer read data and params must both hold through a stall
	a_out_stable: assert property (@(posedge clk) disable iff (rst)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_data)));

endmodule

// File: rtl/wiener_denoise_top.sv
`timescale 1ns/1ps
`include "denoise_macros.svh"

module wiener_denoise_top (
	input  logic                clk,
	input  logic                rst,
	input  logic [`VAR_W-1:0]   noise_var,
	input  denoise_pkg::pixel_t s_data,
	input  logic                s_valid,
	output logic                s_ready,
	output denoise_pkg::pixel_t m_data,
	output logic                m_valid,
	input  logic                m_ready,
	output logic                m_last
);
	import denoise_pkg::*;

	// Buffer write side
	logic                wr_en;
	logic                wr_commit;
	logic                wr_room;
	logic [`BLK_LOG-1:0] wr_addr;
	pixel_t              wr_data;

	// Buffer read side
	logic [`BLK_LOG-1:0] rd_addr;
	pixel_t              rd_data;
	logic                rd_release;

	// Stage handoffs
	logic                 stats_valid;
	logic                 stats_ready;
	logic [3*`SUM_W-1:0]  sums;
	logic [3*`SQ_W-1:0]   sumsqs;
	logic                 params_valid;
	logic                 params_ready;
	logic [3*`CH_W-1:0]   means;
	logic [3*`GAIN_W-1:0] gains;

	block_stats i_block_stats (
		.clk(clk), .rst(rst),
		.s_data(s_data), .s_valid(s_valid), .s_ready(s_ready),
		.wr_en(wr_en), .wr_commit(wr_commit), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_room(wr_room),
		.stats_valid(stats_valid), .stats_ready(stats_ready),
		.sums(sums), .sumsqs(sumsqs)
	);

	block_buffer i_block_buffer (
		.clk(clk), .rst(rst),
		.wr_en(wr_en), .wr_commit(wr_commit), .wr_addr(wr_addr),
		.wr_data(wr_data), .wr_room(wr_room),
		.rd_addr(rd_addr), .rd_data(rd_data), .rd_release(rd_release)
	);

	wiener_gain i_wiener_gain (
		.clk(clk), .rst(rst), .noise_var(noise_var),
		.stats_valid(stats_valid), .stats_ready(stats_ready),
		.sums(sums), .sumsqs(sumsqs),
		.params_valid(params_valid), .params_ready(params_ready),
		.means(means), .gains(gains)
	);

	wiener_apply i_wiener_apply (
		.clk(clk), .rst(rst),
		.params_valid(params_valid), .params_ready(params_ready),
		.means(means), .gains(gains),
		.rd_addr(rd_addr), .rd_data(rd_data), .rd_release(rd_release),
		.m_data(m_data), .m_valid(m_valid), .m_ready(m_ready), .m_last(m_last)
	);

endmodule

// File: testbench/tb_wiener_denoise.sv
`timescale 1ns/1ps
`include "denoise_macros.svh"

module tb_wiener_denoise;
	import denoise_pkg::*;

	localparam int TOTAL_BLOCKS = 32;
	localparam int MAX_CYCLES   = 300 * TOTAL_BLOCKS;

	logic               clk;
	logic               rst;
	logic [`VAR_W-1:0]  noise_var;
	pixel_t             s_data;
	logic               s_valid;
	logic               s_ready;
	pixel_t             m_data;
	logic               m_valid;
	logic               m_ready;
	logic               m_last;

	logic [31:0] blk [64];
	logic [31:0] exp_q [$];
	logic [31:0] alt_q [$];
	logic [31:0] exp_w;
	logic [31:0] alt_w;
	bit          alt_chk;
	bit          ready_rand;
	int          errors;
	int          out_cnt;
	int          cycles;
	int          tests_run;
	int          tests_ok;

	wiener_denoise_top i_dut (
		.clk(clk), .rst(rst), .noise_var(noise_var),
		.s_data(s_data), .s_valid(s_valid), .s_ready(s_ready),
		.m_data(m_data), .m_valid(m_valid), .m_ready(m_ready), .m_last(m_last)
	);

	always #5 clk = !clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, output stream stopped", cycles);
			$display("tests failed");
			$finish;
		end
	end

	// Downstream ready, random or always high
	always @(posedge clk) begin
		#1;
		if (ready_rand)
			m_ready = ($urandom & 1) == 1;
		else
			m_ready = 1'b1;
	end

	// Sampled at the falling edge, where handshake signals are settled
	always @(negedge clk) begin
		if (!rst && m_valid && m_ready) begin
			assert (exp_q.size() != 0) else begin
				$display("Output pixel appeared with no input pixel waiting for it");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_w = exp_q.pop_front();
				alt_w = alt_q.pop_front();
				assert (m_data.word == exp_w) else begin
					$display("[FAIL] m_data: expected %h, got %h", exp_w, m_data.word);
					errors++;
				end
				if (alt_chk)
					assert (m_data.word == alt_w) else begin
						$display("[FAIL] m_data: expected %h, got %h", alt_w, m_data.word);
						errors++;
					end
			end
			assert (m_last == (out_cnt % 64 == 63)) else begin
				$display("[FAIL] m_last: expected %h, got %h", out_cnt % 64 == 63, m_last);
				errors++;
			end
			out_cnt++;
		end
	end

	function automatic int chan(input logic [31:0] w, input int c);
		return int'(w[8*c +: 8]);
	endfunction

	function automatic int clamp_byte(input int v);
		return (v < 0) ? 0 : (v > 255) ? 255 : v;
	endfunction

	// Flat block or random block with a random spread per block
	task automatic gen_block(input int kind);
		logic [31:0] w;
		int spread;
		int base;
		w = $urandom;
		spread = 1 + int'($urandom % 256);
		base = int'($urandom % (257 - spread));
		for (int i = 0; i < 64; i++) begin
			if (kind == 0) begin
				blk[i] = w;
			end else begin
				w = $urandom;
				blk[i] = {w[31:24], 8'(base + int'(w[23:16]) % spread),
					8'(base + int'(w[15:8]) % spread), 8'(base + int'(w[7:0]) % spread)};
			end
		end
	endtask

	// Wiener filter per channel, per block statistics
	task automatic model_block(input logic [`VAR_W-1:0] nv, input int alt_kind);
		int sum [3];
		int sq [3];
		int mean [3];
		int vr [3];
		int gain [3];
		int y [3];
		int d;
		logic [31:0] mw;
		for (int c = 0; c < 3; c++) begin
			sum[c] = 0;
			sq[c] = 0;
			for (int i = 0; i < 64; i++) begin
				sum[c] += chan(blk[i], c);
				sq[c] += chan(blk[i], c) * chan(blk[i], c);
			end
			mean[c] = sum[c] >> 6;
			vr[c] = (sq[c] >> 6) - mean[c] * mean[c];
			d = vr[c] - int'(nv);
			if (d < 0)
				d = 0;
			gain[c] = (vr[c] == 0) ? 0 : (d * 256) / vr[c];
		end
		mw = {8'h00, 8'(mean[2]), 8'(mean[1]), 8'(mean[0])};
		for (int i = 0; i < 64; i++) begin
			for (int c = 0; c < 3; c++)
				y[c] = clamp_byte(mean[c] + ((gain[c] * (chan(blk[i], c) - mean[c])) >>> 8));
			exp_q.push_back({8'h00, 8'(y[2]), 8'(y[1]), 8'(y[0])});
			if (alt_kind == 1)
				alt_q.push_back({8'h00, blk[i][23:0]});
			else if (alt_kind == 2)
				alt_q.push_back(mw);
			else
				alt_q.push_back(32'h0);
		end
	endtask

	// Valid held until the handshake, optional idle gaps
	task automatic send_block(input bit rnd_valid);
		int i;
		bit hs;
		i = 0;
		while (i < 64) begin
			if (!s_valid && (!rnd_valid || ($urandom & 1) == 1)) begin
				s_valid = 1'b1;
				s_data.word = blk[i];
			end
			@(negedge clk);
			hs = s_valid && s_ready;
			@(posedge clk);
			#1;
			if (hs) begin
				s_valid = 1'b0;
				i++;
			end
		end
	endtask

	task automatic run_test(input string name, input int nblk, input int kind,
		input logic [`VAR_W-1:0] nv, input bit rnd_io, input int alt_kind);
		int err_start;
		err_start = errors;
		noise_var = nv;
		ready_rand = rnd_io;
		alt_chk = (alt_kind != 0);
		for (int b = 0; b < nblk; b++) begin
			gen_block(kind);
			model_block(nv, alt_kind);
			send_block(rnd_io);
		end
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		#1;
		tests_run++;
		if (errors == err_start) begin
			tests_ok++;
			$display("%s: ok, %0d blocks", name, nblk);
		end else begin
			$display("%s: %0d errors", name, errors - err_start);
		end
	endtask

	initial begin
		void'($urandom(26));
		clk = 1'b0;
		rst = 1'b1;
		noise_var = '0;
		s_data.word = '0;
		s_valid = 1'b0;
		m_ready = 1'b1;
		ready_rand = 1'b0;
		alt_chk = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle state straight out of reset
		assert (s_ready == 1'b1) else begin
			$display("[FAIL] s_ready: expected %h, got %h", 1'b1, s_ready);
			errors++;
		end
		assert (m_valid == 1'b0) else begin
			$display("[FAIL] m_valid: expected %h, got %h", 1'b0, m_valid);
			errors++;
		end

		run_test("flat block", 2, 0, 16'd400, 1'b0, 1);
		run_test("zero noise", 4, 1, 16'd0, 1'b0, 1);
		run_test("noise 400", 8, 1, 16'd400, 1'b0, 0);
		run_test("max noise", 2, 1, 16'hFFFF, 1'b0, 2);
		run_test("random handshakes", 16, 1, 16'd400, 1'b1, 0);

		$display("%0d of %0d tests ok, %0d check errors", tests_ok, tests_run, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: flist.f
+incdir+rtl
rtl/denoise_pkg.sv
rtl/block_stats.sv
rtl/block_buffer.sv
rtl/wiener_gain.sv
rtl/wiener_apply.sv
rtl/wiener_denoise_top.sv
testbench/tb_wiener_denoise.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_wiener_denoise \
	-f flist.f -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "all tests passed" sim.log \
	&& { echo "Simulation PASS"; exit 0; } \
	|| { echo "Simulation FAIL, see sim.log"; exit 1; }
